/* include/clint_defines.svh */
`ifndef CLINT_DEFINES_SVH
`define CLINT_DEFINES_SVH

// ****************************************
// CLINT configuration
// ****************************************

// Number of harts served by this CLINT
`define CLINT_NUM_HARTS 2

// Clocks per mtime increment
`define CLINT_TICK_DIV 4

// ****************************************
// Address map
// ****************************************

// Software interrupt registers, one word per hart on an 8 byte stride
`define CLINT_MSIP_BASE 16'h0000

// Timer compare registers, 8 bytes per hart
`define CLINT_MTIMECMP_BASE 16'h4000

// Free running timer, low word here and high word at +4
`define CLINT_MTIME_BASE 16'hBFF8

// AXI response codes
`define CLINT_RESP_OKAY 2'd0
`define CLINT_RESP_SLVERR 2'd2

`endif

/* design/clint_pkg.sv */
package clint_pkg;

	// Register region selected by a bus address
	typedef enum logic [1:0] {
		CLINT_REGION_MSIP     = 2'd0,
		CLINT_REGION_MTIMECMP = 2'd1,
		CLINT_REGION_MTIME    = 2'd2,
		CLINT_REGION_NONE     = 2'd3
	} clint_region_e;

	// Field layout of a 16-bit register offset
	typedef struct packed {
		logic [1:0]  region;
		logic [10:0] hart;
		logic        word_hi;
		logic [1:0]  byte_off;
	} clint_addr_fields_t;

	// The same address word seen as a raw offset or as its fields
	typedef union packed {
		logic [15:0]        raw;
		clint_addr_fields_t f;
	} clint_addr_u;

	// Replace the strobed bytes of one 32-bit half of a 64-bit register
	function automatic logic [63:0] strb_merge(
		input logic [63:0] old_val,
		input logic [31:0] wdata,
		input logic [3:0]  wstrb,
		input logic        word_hi
	);
		logic [63:0] mask;
		mask = '0;
		for (int b = 0; b < 4; b++) begin
			mask[b*8 +: 8] = {8{wstrb[b]}};
		end
		if (word_hi) begin
			mask = mask << 32;
		end
		return (old_val & ~mask) | ({wdata, wdata} & mask);
	endfunction

endpackage

/* design/clint_mtime.sv */
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_mtime (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic        word_hi,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic [63:0] mtime
);
	import clint_pkg::*;

	localparam int DIV_W = (`CLINT_TICK_DIV > 1) ? $clog2(`CLINT_TICK_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`CLINT_TICK_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [63:0]      mtime_inc;

	// ****************************************
	// Prescaler
	// ****************************************

	assign tick = (div_cnt == DIV_LAST);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ****************************************
	// Counter
	// ****************************************

	assign mtime_inc = mtime + 64'(tick);

	// Bytes not covered by the strobes keep the advanced count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (we) begin
			mtime <= strb_merge(mtime_inc, wdata, wstrb, word_hi);
		end else begin
			mtime <= mtime_inc;
		end
	end

endmodule

/* design/clint_hart_regs.sv */
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_hart_regs (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        cmp_we,
	input  logic                        msip_we,
	input  logic [10:0]                 wr_hart,
	input  logic                        word_hi,
	input  logic [31:0]                 wdata,
	input  logic [3:0]                  wstrb,
	input  logic [63:0]                 mtime,
	input  logic [10:0]                 rd_hart,
	input  clint_pkg::clint_region_e    rd_region,
	input  logic                        rd_word_hi,
	output logic [31:0]                 rd_data,
	output logic [`CLINT_NUM_HARTS-1:0] timer_irq,
	output logic [`CLINT_NUM_HARTS-1:0] soft_irq
);
	import clint_pkg::*;

	localparam int NH = `CLINT_NUM_HARTS;

	logic [63:0]   mtimecmp [NH];
	logic [NH-1:0] msip;

	// ****************************************
	// Register writes
	// ****************************************

	// The port only raises an enable for a hart index that exists
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int h = 0; h < NH; h++) begin
				mtimecmp[h] <= '1;
			end
			msip <= '0;
		end else begin
			for (int h = 0; h < NH; h++) begin
				if (cmp_we && wr_hart == 11'(h)) begin
					mtimecmp[h] <= strb_merge(mtimecmp[h], wdata, wstrb, word_hi);
				end
				// Only bit 0 of msip is implemented
				if (msip_we && wr_hart == 11'(h) && wstrb[0]) begin
					msip[h] <= wdata[0];
				end
			end
		end
	end

	// ****************************************
	// Interrupts
	// ****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timer_irq <= '0;
		end else begin
			for (int h = 0; h < NH; h++) begin
				timer_irq[h] <= (mtime >= mtimecmp[h]);
			end
		end
	end

	assign soft_irq = msip;

	// ****************************************
	// Read-out
	// ****************************************

	always_comb begin
		rd_data = '0;
		for (int h = 0; h < NH; h++) begin
			if (rd_hart == 11'(h)) begin
				case (rd_region)
					CLINT_REGION_MTIMECMP: begin
						rd_data = rd_word_hi ? mtimecmp[h][63:32] : mtimecmp[h][31:0];
					end
					CLINT_REGION_MSIP: begin
						rd_data = {31'd0, msip[h]};
					end
					default: begin
						rd_data = '0;
					end
				endcase
			end
		end
	end

endmodule

/* design/clint_axil_port.sv */
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_axil_port (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [15:0]              awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  logic [31:0]              wdata,
	input  logic [3:0]               wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  logic                     bready,
	input  logic [15:0]              araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output logic [31:0]              rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  logic                     rready,
	input  logic [63:0]              mtime,
	output logic                     mtime_we,
	output logic                     cmp_we,
	output logic                     msip_we,
	output logic [10:0]              wr_hart,
	output logic                     word_hi,
	output logic [31:0]              wr_data,
	output logic [3:0]               wr_strb,
	output logic [10:0]              rd_hart,
	output clint_pkg::clint_region_e rd_region,
	output logic                     rd_word_hi,
	input  logic [31:0]              rd_data
);
	import clint_pkg::*;

	localparam logic [15:0] MSIP_BASE   = `CLINT_MSIP_BASE;
	localparam logic [15:0] CMP_BASE    = `CLINT_MTIMECMP_BASE;
	localparam logic [15:0] MTIME_BASE  = `CLINT_MTIME_BASE;
	localparam logic [1:0]  RESP_OKAY   = `CLINT_RESP_OKAY;
	localparam logic [1:0]  RESP_SLVERR = `CLINT_RESP_SLVERR;

	typedef enum logic {W_IDLE, W_RESP} wr_state_e;
	typedef enum logic {R_IDLE, R_DATA} rd_state_e;

	// ****************************************
	// Address decode
	// ****************************************

	// msip lives only in the low word of its 8 byte slot
	function automatic clint_region_e addr_region(input clint_addr_u addr);
		clint_region_e region;
		if (addr.raw[15:3] == MTIME_BASE[15:3]) begin
			region = CLINT_REGION_MTIME;
		end else if (addr.raw[15:14] == CMP_BASE[15:14]) begin
			region = CLINT_REGION_MTIMECMP;
		end else if (addr.raw[15:14] == MSIP_BASE[15:14] && addr.raw[2] == MSIP_BASE[2]) begin
			region = CLINT_REGION_MSIP;
		end else begin
			region = CLINT_REGION_NONE;
		end
		return region;
	endfunction

	function automatic logic addr_miss(input clint_region_e region, input logic [10:0] hart);
		logic miss;
		case (region)
			CLINT_REGION_NONE:  miss = 1'b1;
			CLINT_REGION_MTIME: miss = 1'b0;
			default:            miss = (hart >= 11'(`CLINT_NUM_HARTS));
		endcase
		return miss;
	endfunction

	clint_addr_u   wr_addr;
	clint_addr_u   rd_addr;
	clint_region_e wr_region;
	logic          wr_miss;
	logic          rd_miss;
	logic          wr_fire;
	logic          rd_fire;
	logic [31:0]   rd_word;
	wr_state_e     wr_state;
	wr_state_e     wr_state_next;
	rd_state_e     rd_state;
	rd_state_e     rd_state_next;

	// ****************************************
	// Write channel
	// ****************************************

	assign wr_addr   = awaddr;
	assign wr_region = addr_region(wr_addr);
	assign wr_miss   = addr_miss(wr_region, wr_addr.f.hart);

	// Address and data are taken together, never while a response waits
	assign awready = awvalid & wvalid & (wr_state == W_IDLE);
	assign wready  = awready;
	assign wr_fire = awvalid & awready;

	assign mtime_we = wr_fire & ~wr_miss & (wr_region == CLINT_REGION_MTIME);
	assign cmp_we   = wr_fire & ~wr_miss & (wr_region == CLINT_REGION_MTIMECMP);
	assign msip_we  = wr_fire & ~wr_miss & (wr_region == CLINT_REGION_MSIP);
	assign wr_hart  = wr_addr.f.hart;
	assign word_hi  = wr_addr.f.word_hi;
	assign wr_data  = wdata;
	assign wr_strb  = wstrb;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_state <= W_IDLE;
		end else begin
			wr_state <= wr_state_next;
		end
	end

	always_comb begin
		wr_state_next = wr_state;
		case (wr_state)
			W_IDLE: if (wr_fire) wr_state_next = W_RESP;
			W_RESP: if (bready) wr_state_next = W_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp <= wr_miss ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign bvalid = (wr_state == W_RESP);

	// ****************************************
	// Read channel
	// ****************************************

	assign rd_addr    = araddr;
	assign rd_region  = addr_region(rd_addr);
	assign rd_miss    = addr_miss(rd_region, rd_addr.f.hart);
	assign rd_hart    = rd_addr.f.hart;
	assign rd_word_hi = rd_addr.f.word_hi;

	assign arready = (rd_state == R_IDLE);
	assign rd_fire = arvalid & arready;

	always_comb begin
		if (rd_miss) begin
			rd_word = '0;
		end else if (rd_region == CLINT_REGION_MTIME) begin
			rd_word = rd_word_hi ? mtime[63:32] : mtime[31:0];
		end else begin
			rd_word = rd_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state <= R_IDLE;
		end else begin
			rd_state <= rd_state_next;
		end
	end

	always_comb begin
		rd_state_next = rd_state;
		case (rd_state)
			R_IDLE: if (rd_fire) rd_state_next = R_DATA;
			R_DATA: if (rready) rd_state_next = R_IDLE;
		endcase
	end

	// Data is captured once and held until the master takes it
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= rd_word;
			rresp <= rd_miss ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign rvalid = (rd_state == R_DATA);

endmodule

/* design/clint_top.sv */
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [15:0]                 awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [31:0]                 wdata,
	input  logic [3:0]                  wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [15:0]                 araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [31:0]                 rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output logic [`CLINT_NUM_HARTS-1:0] timer_irq,
	output logic [`CLINT_NUM_HARTS-1:0] soft_irq
);
	import clint_pkg::*;

	logic [63:0]   mtime;
	logic          mtime_we;
	logic          cmp_we;
	logic          msip_we;
	logic [10:0]   wr_hart;
	logic          word_hi;
	logic [31:0]   wr_data;
	logic [3:0]    wr_strb;
	logic [10:0]   rd_hart;
	clint_region_e rd_region;
	logic          rd_word_hi;
	logic [31:0]   rd_data;

	// Bus port
	clint_axil_port u_port (
		.clk        (clk),
		.rst_n      (rst_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.mtime      (mtime),
		.mtime_we   (mtime_we),
		.cmp_we     (cmp_we),
		.msip_we    (msip_we),
		.wr_hart    (wr_hart),
		.word_hi    (word_hi),
		.wr_data    (wr_data),
		.wr_strb    (wr_strb),
		.rd_hart    (rd_hart),
		.rd_region  (rd_region),
		.rd_word_hi (rd_word_hi),
		.rd_data    (rd_data)
	);

	// Shared timebase
	clint_mtime u_mtime (
		.clk     (clk),
		.rst_n   (rst_n),
		.we      (mtime_we),
		.word_hi (word_hi),
		.wdata   (wr_data),
		.wstrb   (wr_strb),
		.mtime   (mtime)
	);

	// Per-hart compare and software interrupt registers
	clint_hart_regs u_harts (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmp_we     (cmp_we),
		.msip_we    (msip_we),
		.wr_hart    (wr_hart),
		.word_hi    (word_hi),
		.wdata      (wr_data),
		.wstrb      (wr_strb),
		.mtime      (mtime),
		.rd_hart    (rd_hart),
		.rd_region  (rd_region),
		.rd_word_hi (rd_word_hi),
		.rd_data    (rd_data),
		.timer_irq  (timer_irq),
		.soft_irq   (soft_irq)
	);

endmodule

/* dv/clint_sva.sv */
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_sva (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        awready,
	input logic                        wvalid,
	input logic [1:0]                  bresp,
	input logic                        bvalid,
	input logic                        bready,
	input logic [31:0]                 rdata,
	input logic [1:0]                  rresp,
	input logic                        rvalid,
	input logic                        rready,
	input logic [`CLINT_NUM_HARTS-1:0] timer_irq,
	input logic [`CLINT_NUM_HARTS-1:0] soft_irq
);

	int unsigned b_fails = 0;
	int unsigned r_fails = 0;
	int unsigned aw_fails = 0;
	int unsigned rst_fails = 0;
	int unsigned fail_cnt;

	assign fail_cnt = b_fails + r_fails + aw_fails + rst_fails;

	// ****************************************
	// Response channels
	// ****************************************

	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else begin
		b_fails++;
		$error("bvalid dropped or bresp changed before bready");
	end

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else begin
		r_fails++;
		$error("rvalid dropped or read payload changed before rready");
	end

	// Address and data are only ever accepted together
	aw_with_w: assert property (@(posedge clk) disable iff (!rst_n) awready |-> wvalid)
	else begin
		aw_fails++;
		$error("awready high without wvalid");
	end

	// Every edge that sees reset leaves outputs quiet
	reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !bvalid && !rvalid && timer_irq == '0 && soft_irq == '0)
	else begin
		rst_fails++;
		$error("Valid or interrupt output high after a reset edge");
	end

endmodule

bind clint_top clint_sva u_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.awready   (awready),
	.wvalid    (wvalid),
	.bresp     (bresp),
	.bvalid    (bvalid),
	.bready    (bready),
	.rdata     (rdata),
	.rresp     (rresp),
	.rvalid    (rvalid),
	.rready    (rready),
	.timer_irq (timer_irq),
	.soft_irq  (soft_irq)
);

/* dv/clint_tb.sv */
`timescale 1ns/1ps
`include "clint_defines.svh"

module clint_tb;

	localparam int          NH         = `CLINT_NUM_HARTS;
	localparam int          CLK_PERIOD = 4;
	localparam time         TICK_NS    = time'(CLK_PERIOD * `CLINT_TICK_DIV);
	// Upper bound on the bus operations of the whole run
	localparam int          NUM_OPS    = 80;
	localparam logic [15:0] MSIP_BASE  = `CLINT_MSIP_BASE;
	localparam logic [15:0] CMP_BASE   = `CLINT_MTIMECMP_BASE;
	localparam logic [15:0] MTIME_BASE = `CLINT_MTIME_BASE;
	localparam logic [1:0]  OKAY       = `CLINT_RESP_OKAY;
	localparam logic [1:0]  SLVERR     = `CLINT_RESP_SLVERR;

	logic          clk;
	logic          rst_n;
	logic [15:0]   awaddr;
	logic          awvalid;
	logic          awready;
	logic [31:0]   wdata;
	logic [3:0]    wstrb;
	logic          wvalid;
	logic          wready;
	logic [1:0]    bresp;
	logic          bvalid;
	logic          bready;
	logic [15:0]   araddr;
	logic          arvalid;
	logic          arready;
	logic [31:0]   rdata;
	logic [1:0]    rresp;
	logic          rvalid;
	logic          rready;
	logic [NH-1:0] timer_irq;
	logic [NH-1:0] soft_irq;

	logic [63:0]   cmp_model [NH];
	logic [NH-1:0] msip_model;
	logic [31:0]   lcg_state = 32'hd44bc423;
	int unsigned   errors = 0;

	clint_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ****************************************
	// Helpers
	// ****************************************

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				result[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return result;
	endfunction

	function automatic logic [15:0] cmp_addr(input int hart, input logic hi);
		return CMP_BASE + 16'(hart * 8) + (hi ? 16'd4 : 16'd0);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// Outputs are sampled 1 ns after the falling edge that drove the inputs
	task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int unsigned delay;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		#1;
		while (!(awready && wready)) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		delay = (lcg_next() >> 16) % 3;
		repeat (delay) @(negedge clk);
		bready = 1'b1;
		#1;
		while (!bvalid) begin
			@(negedge clk);
			#1;
		end
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int unsigned delay;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		#1;
		while (!arready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		arvalid = 1'b0;
		delay = (lcg_next() >> 16) % 3;
		repeat (delay) @(negedge clk);
		rready = 1'b1;
		#1;
		while (!rvalid) begin
			@(negedge clk);
			#1;
		end
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic write_expect_okay(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [1:0] resp;
		axil_write(addr, data, strb, resp);
		check_value("bresp", 32'(OKAY), 32'(resp));
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [31:0] expected,
		input string name);
		logic [31:0] data;
		logic [1:0]  resp;
		axil_read(addr, data, resp);
		check_value("rresp", 32'(OKAY), 32'(resp));
		check_value(name, expected, data);
	endtask

	task automatic set_cmp(input int hart, input logic [63:0] value);
		write_expect_okay(cmp_addr(hart, 1'b1), value[63:32], 4'hf);
		cmp_model[hart][63:32] = value[63:32];
		write_expect_okay(cmp_addr(hart, 1'b0), value[31:0], 4'hf);
		cmp_model[hart][31:0] = value[31:0];
	endtask

	// timer_irq is registered, so allow it two more cycles to settle
	task automatic expect_timer(input logic [NH-1:0] expected);
		int n;
		n = 0;
		while (timer_irq !== expected && n < 2) begin
			@(negedge clk);
			n++;
		end
		check_value("timer_irq", 32'(expected), 32'(timer_irq));
	endtask

	// ****************************************
	// Tests
	// ****************************************

	task automatic mtimecmp_strobe_writes();
		logic [31:0] data;
		logic [31:0] rnd;
		logic [3:0]  strb;
		logic        hi;
		for (int h = 0; h < NH; h++) begin
			for (int w = 0; w < 2; w++) begin
				hi = (w == 1);
				for (int n = 0; n < 4; n++) begin
					data = lcg_next();
					rnd = lcg_next();
					strb = rnd[19:16];
					write_expect_okay(cmp_addr(h, hi), data, strb);
					if (hi) begin
						cmp_model[h][63:32] = merge_bytes(cmp_model[h][63:32], data, strb);
					end else begin
						cmp_model[h][31:0] = merge_bytes(cmp_model[h][31:0], data, strb);
					end
					read_expect(cmp_addr(h, hi),
						hi ? cmp_model[h][63:32] : cmp_model[h][31:0], "mtimecmp");
				end
			end
		end
	endtask

	task automatic msip_set_clear();
		for (int h = 0; h < NH; h++) begin
			for (int v = 1; v >= 0; v--) begin
				write_expect_okay(MSIP_BASE + 16'(h * 8), 32'(v), 4'hf);
				msip_model[h] = (v == 1);
				check_value("soft_irq", 32'(msip_model), 32'(soft_irq));
				read_expect(MSIP_BASE + 16'(h * 8), 32'(v), "msip");
			end
		end
	endtask

	task automatic mtime_advance_bounds();
		logic [31:0] base;
		logic [31:0] upper;
		logic [31:0] data;
		logic [1:0]  resp;
		time         t0;
		base = 32'h7fff_ff00;
		write_expect_okay(MTIME_BASE + 16'd4, 32'd0, 4'hf);
		t0 = $time;
		write_expect_okay(MTIME_BASE, base, 4'hf);
		read_expect(MTIME_BASE + 16'd4, 32'd0, "mtime_hi");
		for (int i = 0; i < 4; i++) begin
			repeat (lcg_next() % 8) @(negedge clk);
			axil_read(MTIME_BASE, data, resp);
			upper = base + 32'(($time - t0) / TICK_NS) + 32'd1;
			check_value("rresp", 32'(OKAY), 32'(resp));
			assert (data >= base && data <= upper) else begin
				errors++;
				$display("ERR %0t mtime_lo expected %h to %h actual %h",
					$time, base, upper, data);
			end
		end
	endtask

	task automatic timer_irq_compare();
		for (int h = 0; h < NH; h++) begin
			set_cmp(h, '1);
		end
		expect_timer('0);
		for (int h = 0; h < NH; h++) begin
			set_cmp(h, 64'd0);
			expect_timer(NH'(1) << h);
			write_expect_okay(cmp_addr(h, 1'b1), 32'hffff_ffff, 4'hf);
			cmp_model[h][63:32] = 32'hffff_ffff;
			expect_timer('0);
			write_expect_okay(cmp_addr(h, 1'b0), 32'hffff_ffff, 4'hf);
			cmp_model[h][31:0] = 32'hffff_ffff;
		end
	endtask

	task automatic unmapped_access_errors();
		logic [15:0] bad [4];
		logic [31:0] data;
		logic [1:0]  resp;
		bad[0] = 16'h8000;
		bad[1] = MSIP_BASE + 16'h0004;
		bad[2] = MSIP_BASE + 16'(NH * 8);
		bad[3] = CMP_BASE + 16'(NH * 8);
		for (int i = 0; i < 4; i++) begin
			axil_write(bad[i], 32'h0000_0001, 4'hf, resp);
			check_value("bresp", 32'(SLVERR), 32'(resp));
			axil_read(bad[i], data, resp);
			check_value("rresp", 32'(SLVERR), 32'(resp));
		end
		for (int h = 0; h < NH; h++) begin
			read_expect(cmp_addr(h, 1'b0), cmp_model[h][31:0], "mtimecmp");
			read_expect(cmp_addr(h, 1'b1), cmp_model[h][63:32], "mtimecmp");
			read_expect(MSIP_BASE + 16'(h * 8), 32'(msip_model[h]), "msip");
		end
		check_value("soft_irq", 32'(msip_model), 32'(soft_irq));
	endtask

	// ****************************************
	// Sequence
	// ****************************************

	initial begin
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		msip_model = '0;
		for (int h = 0; h < NH; h++) begin
			cmp_model[h] = '1;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		mtimecmp_strobe_writes();
		msip_set_clear();
		mtime_advance_bounds();
		timer_irq_compare();
		unmapped_access_errors();

		repeat (4) @(negedge clk);
		$display("Errors: %0d value checks, %0d assertion failures",
			errors, uut.u_sva.fail_cnt);
		if (errors == 0 && uut.u_sva.fail_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(NUM_OPS * 64 * CLK_PERIOD);
		$display("Watchdog expired before the test sequence finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
design/clint_pkg.sv
design/clint_mtime.sv
design/clint_hart_regs.sv
design/clint_axil_port.sv
design/clint_top.sv
dv/clint_sva.sv
dv/clint_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the CLINT testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module clint_tb \
	-f project.f -o clint_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/clint_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi

exit 0
